// ==== flist.f ====
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_sequencer.sv
hdl/cpu_datapath.sv
hdl/cpu_top.sv
dv/tb_clock_gen.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
    -f flist.f -Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int    NUM_TESTS     = 10;
    localparam int    PROG_WORDS    = 6;
    localparam int    MEM_WORDS     = 1 << ADDR_WIDTH;
    localparam int    HALT_TIMEOUT  = 500;
    localparam int    RESET_TIMEOUT = 10;
    localparam addr_t PROG_BASE     = 6'd8;

    typedef struct packed {
        data_t [PROG_WORDS-1:0] prog;
        data_t [7:0]            init;     // addresses 0..7
        data_t                  in_val;
        data_t                  exp_out;
        addr_t                  res_addr;
        data_t                  exp_res;
        addr_t                  exp_pc;
    } test_vec_t;

    logic      clk;
    logic      rst_n;
    logic      reset_req;
    data_t     mem_in = '0;
    data_t     in_data;
    logic      mem_we;
    addr_t     mem_addr;
    data_t     mem_data;
    data_t     out_data;
    addr_t     pc;
    logic      halt;
    data_t     mem [MEM_WORDS];
    data_t     rd_word;
    test_vec_t tests [NUM_TESTS];
    string     names [NUM_TESTS];
    int        test_errs;
    int        passed;
    int        failed;

    tb_clock_gen u_clock_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    cpu_top #(
        .RESET_PC (PROG_BASE)
    ) u_cpu_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_in   (mem_in),
        .in       (in_data),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .out      (out_data),
        .pc       (pc),
        .halt     (halt)
    );

    // memory writes on the edge and returns read data one clock after the address
    always @(posedge clk) begin
        rd_word = mem[mem_addr];
        if (mem_we) mem[mem_addr] = mem_data;
        #1 mem_in = rd_word;
    end

    function automatic data_t fill_pattern(input addr_t addr);
        return {2'b10, addr, ~addr, 2'b01};
    endfunction

    function automatic data_t pointer_to(input data_t noise, input addr_t target);
        return {noise[DATA_WIDTH-1:ADDR_WIDTH], target};  // only the low 6 bits point
    endfunction

    function automatic logic [3:0] dir_op(input logic [2:0] addr);
        return {1'b0, addr};
    endfunction

    function automatic logic [3:0] ind_op(input logic [2:0] addr);
        return {1'b1, addr};
    endfunction

    function automatic data_t encode_instr(input logic [3:0] op, input logic [3:0] a,
                                           input logic [3:0] b, input logic [3:0] c);
        return {op, a, b, c};
    endfunction

    task automatic check_data(input string test, input string what,
                              input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string test, input string what,
                              input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %0d, actual %0d", test, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic define_test(input int idx, input string name, input data_t word0,
                               input addr_t res, input data_t exp_res);
        names[idx]          = name;
        tests[idx].prog[0]  = word0;
        tests[idx].res_addr = res;
        tests[idx].exp_res  = exp_res;
    endtask

    task automatic build_table();
        data_t                   rb;
        data_t                   rc;
        data_t                   rk;
        data_t                   rin;
        data_t                   rv;
        data_t                   noise;
        logic [2*DATA_WIDTH-1:0] prod;
        rb    = data_t'($urandom);
        rc    = data_t'($urandom);
        rk    = data_t'($urandom);
        rin   = data_t'($urandom);
        rv    = data_t'($urandom);
        noise = data_t'($urandom);
        prod  = rb * rc;
        for (int i = 0; i < NUM_TESTS; i++) begin
            tests[i]         = '0;
            tests[i].init[1] = rb;
            tests[i].init[2] = rc;
            tests[i].exp_pc  = PROG_BASE + 6'd2;  // one instruction and then STOP
            for (int w = 0; w < PROG_WORDS; w++) begin
                tests[i].prog[w] = encode_instr(OC_STOP, 4'h0, 4'h0, 4'h0);
            end
        end
        define_test(0, "add_direct", encode_instr(OC_ADD, dir_op(3), dir_op(1), dir_op(2)),
                    6'd3, rb + rc);
        define_test(1, "sub_direct", encode_instr(OC_SUB, dir_op(4), dir_op(1), dir_op(2)),
                    6'd4, rb - rc);
        define_test(2, "mul_direct", encode_instr(OC_MUL, dir_op(5), dir_op(1), dir_op(2)),
                    6'd5, prod[DATA_WIDTH-1:0]);
        // B through the pointer at 1 and the result through the pointer at 3
        define_test(3, "indirect_b_a", encode_instr(OC_ADD, ind_op(3), ind_op(1), dir_op(2)),
                    6'd50, fill_pattern(6'd40) + rc);
        tests[3].init[1] = pointer_to(noise, 6'd40);
        tests[3].init[3] = pointer_to(rv, 6'd50);
        define_test(4, "indirect_c", encode_instr(OC_SUB, dir_op(4), dir_op(2), ind_op(5)),
                    6'd4, rc - fill_pattern(6'd41));
        tests[4].init[5] = pointer_to(noise, 6'd41);
        define_test(5, "mov_reg", encode_instr(OC_MOV, dir_op(6), dir_op(1), dir_op(0)),
                    6'd6, rb);
        define_test(6, "mov_const", encode_instr(OC_MOV, dir_op(7), dir_op(0), ind_op(0)),
                    6'd7, rk);
        tests[6].prog[1] = rk;
        tests[6].exp_pc  = PROG_BASE + 6'd3;  // constant word counts too
        define_test(7, "in_out", encode_instr(OC_IN, dir_op(3), 4'h0, 4'h0), 6'd3, rin);
        tests[7].prog[1] = encode_instr(OC_OUT, dir_op(3), 4'h0, 4'h0);
        tests[7].in_val  = rin;
        tests[7].exp_out = rin;
        tests[7].exp_pc  = PROG_BASE + 6'd3;
        // opcode 4 was DIV and is now skipped
        define_test(8, "skip_div", encode_instr(4'd4, dir_op(3), dir_op(1), dir_op(2)),
                    6'd3, rv);
        tests[8].init[3] = rv;
        define_test(9, "out_indirect", encode_instr(OC_OUT, ind_op(1), 4'h0, 4'h0),
                    6'd45, fill_pattern(6'd45));
        tests[9].init[1] = pointer_to(noise, 6'd45);
        tests[9].exp_out = fill_pattern(6'd45);
    endtask

    task automatic wait_reset_level(input logic level, input string test);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rst_n !== level && cycles < RESET_TIMEOUT);
        if (rst_n !== level) begin
            $display("ERROR %s: rst_n did not reach %b within %0d cycles", test, level,
                     RESET_TIMEOUT);
            test_errs++;
        end
    endtask

    task automatic run_test(input int idx);
        test_vec_t t;
        int        cycles;
        t         = tests[idx];
        test_errs = 0;
        reset_req = 1'b1;
        @(posedge clk);
        #1 reset_req = 1'b0;
        wait_reset_level(1'b0, names[idx]);
        @(posedge clk);
        #1;
        for (int a = 0; a < MEM_WORDS; a++) mem[a] = fill_pattern(addr_t'(a));
        for (int a = 0; a < 8; a++) mem[a] = t.init[a];
        for (int w = 0; w < PROG_WORDS; w++) mem[PROG_BASE + w] = t.prog[w];
        in_data = t.in_val;
        wait_reset_level(1'b1, names[idx]);
        check_data(names[idx], "out after reset", '0, out_data);
        cycles = 0;
        while (halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("ERROR %s: program did not halt within %0d cycles", names[idx],
                     HALT_TIMEOUT);
            test_errs++;
        end else begin
            check_data(names[idx], "out", t.exp_out, out_data);
            check_data(names[idx], $sformatf("mem[%0d]", t.res_addr), t.exp_res,
                       mem[t.res_addr]);
            check_addr(names[idx], "pc", t.exp_pc, pc);
        end
        if (test_errs == 0) begin
            passed++;
            $display("PASS %s", names[idx]);
        end else begin
            failed++;
            $display("FAIL %s (%0d errors)", names[idx], test_errs);
        end
    endtask

    initial begin
        reset_req = 1'b0;
        in_data   = '0;
        passed    = 0;
        failed    = 0;
        void'($urandom(32'h2896_2f68));
        build_table();
        for (int i = 0; i < NUM_TESTS; i++) run_test(i);
        $display("tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 NUM_TESTS, passed, failed, u_cpu_top.u_checker.fail_count);
        if (failed == 0 && u_cpu_top.u_checker.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  mem_we,
    input addr_t mem_addr,
    input logic  halt
);

    int unsigned fail_count = 0;  // failed assertions so far

    // first sampled edge out of reset still sees the reset state
    reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !mem_we && !halt)
        else begin
            fail_count++;
            $error("mem_we or halt high on the first edge after reset");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) $past(halt) |-> halt)
        else begin
            fail_count++;
            $error("halt dropped before reset");
        end

    no_write_halted: assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && halt))
        else begin
            fail_count++;
            $error("memory write while halted");
        end

    addr_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(mem_addr))
        else begin
            fail_count++;
            $error("mem_addr has unknown bits");
        end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .halt     (halt)
);

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    input  logic reset_req,  // sampled on the rising edge
    output logic clk,
    output logic rst_n
);

    logic        clk_q = 1'b0;
    logic        rst_q = 1'b0;  // in reset from time zero
    int unsigned hold  = RESET_CYCLES;

    always #(PERIOD_NS / 2) clk_q = ~clk_q;

    // rst_n moves 1 ns after the edge, like every other DUT input
    always @(posedge clk_q) begin
        if (reset_req) hold = RESET_CYCLES;
        #1;
        if (hold != 0) begin
            rst_q = 1'b0;
            hold  = hold - 1;
        end else begin
            rst_q = 1'b1;
        end
    end

    assign clk   = clk_q;
    assign rst_n = rst_q;

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = addr_t'(8)
) (
    input  logic  clk,
    input  logic  rst_n,
    input  data_t mem_in,
    input  data_t in,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_data,
    output data_t out,
    output addr_t pc,
    output logic  halt
);

    dp_ctrl_t ctrl;
    mem_req_t mem_req;  // we and addr from the sequencer, data from the datapath

    cpu_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_in   (mem_in),
        .mem_we   (mem_req.we),
        .mem_addr (mem_req.addr),
        .pc       (pc),
        .halt     (halt),
        .ctrl     (ctrl)
    );

    cpu_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_in   (mem_in),
        .in       (in),
        .ctrl     (ctrl),
        .mem_data (mem_req.data),
        .out      (out)
    );

    assign mem_we   = mem_req.we;
    assign mem_addr = mem_req.addr;
    assign mem_data = mem_req.data;

endmodule

// ==== hdl/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  data_t    mem_in,
    input  data_t    in,
    input  dp_ctrl_t ctrl,
    output data_t    mem_data,
    output data_t    out
);

    data_t opa_q;
    data_t opb_q;
    data_t opc_q;
    data_t alu_q;
    data_t alu_f;
    data_t wr_data;
    data_t mem_data_q;
    data_t out_q;

    // B and C feed the ALU, A only goes to the output port
    cpu_alu u_alu (
        .op (ctrl.alu_op),
        .a  (opb_q),
        .b  (opc_q),
        .f  (alu_f)
    );

    always_comb begin
        case (ctrl.wr_src)
            WR_IN:    wr_data = in;
            WR_CONST: wr_data = ctrl.imm;
            WR_OPB:   wr_data = opb_q;  // plain MOV
            default:  wr_data = alu_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.opa_ld) opa_q <= mem_in;
        if (ctrl.opb_ld) opb_q <= mem_in;
        if (ctrl.opc_ld) opc_q <= mem_in;
        if (ctrl.alu_ld) alu_q <= alu_f;
        if (ctrl.wr_ld) mem_data_q <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (ctrl.out_ld) begin
            out_q <= opa_q;
        end
    end

    assign mem_data = mem_data_q;
    assign out      = out_q;

endmodule

// ==== hdl/cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = addr_t'(8)
) (
    input  logic     clk,
    input  logic     rst_n,
    input  data_t    mem_in,
    output logic     mem_we,
    output addr_t    mem_addr,
    output addr_t    pc,
    output logic     halt,
    output dp_ctrl_t ctrl
);

    typedef enum logic [3:0] {
        S_INIT, S_FETCH, S_FETCH_LD, S_DECODE, S_CONST, S_CONST_LD,
        S_RD, S_RD_IND, S_RD_LD, S_ALU, S_OUT, S_WR, S_WR_PTR, S_STOP
    } state_t;

    typedef enum logic [1:0] {SEL_A, SEL_B, SEL_C} sel_t;

    state_t    state_q;
    state_t    state_d;
    addr_t     pc_q;
    addr_t     pc_d;
    logic      mem_we_q;
    logic      mem_we_d;
    addr_t     mem_addr_q;
    addr_t     mem_addr_d;
    logic      rd_wait_q;  // set while waiting out the memory latency
    logic      rd_wait_d;
    sel_t      sel_q;      // operand being read
    sel_t      sel_d;
    mem_word_u ir_q;
    logic      ir_ld;
    data_t     imm_q;
    logic      imm_ld;
    opcode_t   opcode;
    operand_t  cur_op;
    alu_op_t   alu_op;
    wr_src_t   wr_src;

    assign opcode = ir_q.instr.opcode;

    always_comb begin
        case (sel_q)
            SEL_B:   cur_op = ir_q.instr.b;
            SEL_C:   cur_op = ir_q.instr.c;
            default: cur_op = ir_q.instr.a;
        endcase
    end

    always_comb begin
        case (opcode)
            OC_SUB:  alu_op = ALU_SUB;
            OC_MUL:  alu_op = ALU_MUL;
            default: alu_op = ALU_ADD;
        endcase
        case (opcode)
            OC_IN:   wr_src = WR_IN;
            OC_MOV:  wr_src = ir_q.instr.c.ind ? WR_CONST : WR_OPB;
            default: wr_src = WR_ALU;
        endcase
    end

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        mem_we_d   = 1'b0;
        mem_addr_d = mem_addr_q;
        rd_wait_d  = rd_wait_q;
        sel_d      = sel_q;
        ir_ld      = 1'b0;
        imm_ld     = 1'b0;
        ctrl        = '0;
        ctrl.wr_src = wr_src;
        ctrl.alu_op = alu_op;
        ctrl.imm    = imm_q;

        case (state_q)
            S_INIT: begin
                pc_d    = RESET_PC;
                state_d = S_FETCH;
            end
            S_FETCH, S_CONST: begin  // both read the word at pc
                if (!rd_wait_q) begin
                    mem_addr_d = pc_q;
                    pc_d       = pc_q + 1'b1;
                    rd_wait_d  = 1'b1;
                end else begin
                    rd_wait_d = 1'b0;
                    state_d   = (state_q == S_FETCH) ? S_FETCH_LD : S_CONST_LD;
                end
            end
            S_FETCH_LD: begin
                ir_ld   = 1'b1;
                state_d = S_DECODE;
            end
            S_DECODE: begin
                case (opcode)
                    OC_MOV: begin
                        sel_d   = SEL_B;
                        state_d = ir_q.instr.c.ind ? S_CONST : S_RD;
                    end
                    OC_ADD, OC_SUB, OC_MUL: begin
                        sel_d   = SEL_B;
                        state_d = S_RD;
                    end
                    OC_IN:   state_d = S_WR;
                    OC_OUT: begin
                        sel_d   = SEL_A;
                        state_d = S_RD;
                    end
                    OC_STOP: state_d = S_STOP;
                    default: state_d = S_FETCH;  // unknown opcode, skip it
                endcase
            end
            S_CONST_LD: begin
                imm_ld  = 1'b1;
                state_d = S_WR;
            end
            S_RD: begin
                if (!rd_wait_q) begin
                    mem_addr_d = addr_t'(cur_op.addr);
                    rd_wait_d  = 1'b1;
                end else begin
                    rd_wait_d = 1'b0;
                    state_d   = cur_op.ind ? S_RD_IND : S_RD_LD;
                end
            end
            S_RD_IND: begin
                if (!rd_wait_q) begin
                    mem_addr_d = mem_in[ADDR_WIDTH-1:0];  // pointer is on mem_in now
                    rd_wait_d  = 1'b1;
                end else begin
                    rd_wait_d = 1'b0;
                    state_d   = S_RD_LD;
                end
            end
            S_RD_LD: begin
                case (sel_q)
                    SEL_A: begin
                        ctrl.opa_ld = 1'b1;
                        state_d     = S_OUT;
                    end
                    SEL_B: begin
                        ctrl.opb_ld = 1'b1;
                        sel_d       = SEL_C;
                        state_d     = (opcode == OC_MOV) ? S_WR : S_RD;
                    end
                    default: begin
                        ctrl.opc_ld = 1'b1;
                        state_d     = S_ALU;
                    end
                endcase
            end
            S_ALU: begin
                ctrl.alu_ld = 1'b1;
                state_d     = S_WR;
            end
            S_OUT: begin
                ctrl.out_ld = 1'b1;
                state_d     = S_FETCH;
            end
            S_WR: begin
                if (ir_q.instr.a.ind) begin
                    // fetch the pointer first
                    if (!rd_wait_q) begin
                        mem_addr_d = addr_t'(ir_q.instr.a.addr);
                        rd_wait_d  = 1'b1;
                    end else begin
                        rd_wait_d = 1'b0;
                        state_d   = S_WR_PTR;
                    end
                end else begin
                    ctrl.wr_ld = 1'b1;  // data lands together with mem_we
                    mem_we_d   = 1'b1;
                    mem_addr_d = addr_t'(ir_q.instr.a.addr);
                    state_d    = S_FETCH;
                end
            end
            S_WR_PTR: begin
                ctrl.wr_ld = 1'b1;
                mem_we_d   = 1'b1;
                mem_addr_d = mem_in[ADDR_WIDTH-1:0];
                state_d    = S_FETCH;
            end
            S_STOP:  state_d = S_STOP;  // held until reset
            default: state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_INIT;
            pc_q       <= '0;
            mem_we_q   <= 1'b0;
            mem_addr_q <= '0;
            rd_wait_q  <= 1'b0;
            sel_q      <= SEL_A;
        end else begin
            state_q    <= state_d;
            pc_q       <= pc_d;
            mem_we_q   <= mem_we_d;
            mem_addr_q <= mem_addr_d;
            rd_wait_q  <= rd_wait_d;
            sel_q      <= sel_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_ld) ir_q.raw <= mem_in;
        if (imm_ld) imm_q <= mem_in;
    end

    assign mem_we   = mem_we_q;
    assign mem_addr = mem_addr_q;
    assign pc       = pc_q;
    assign halt     = (state_q == S_STOP);

endmodule

// ==== hdl/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu
    import cpu_pkg::*;
(
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    output data_t   f
);

    always_comb begin
        case (op)
            ALU_ADD: f = a + b;
            ALU_SUB: f = a - b;  // wraps modulo 2^16
            ALU_MUL: f = a * b;  // low half of the product
            default: f = '0;
        endcase
    end

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int ADDR_WIDTH  = 6;   // 64 words of memory
    localparam int DATA_WIDTH  = 16;
    localparam int FIELD_WIDTH = 3;   // operand fields reach addresses 0..7 only

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef enum logic [3:0] {
        OC_MOV  = 4'd0,
        OC_ADD  = 4'd1,
        OC_SUB  = 4'd2,
        OC_MUL  = 4'd3,
        OC_IN   = 4'd7,
        OC_OUT  = 4'd8,
        OC_STOP = 4'd15
    } opcode_t;

    typedef struct packed {
        logic                   ind;  // 1 = the field addresses a pointer
        logic [FIELD_WIDTH-1:0] addr;
    } operand_t;

    typedef struct packed {
        opcode_t  opcode;
        operand_t a;  // destination
        operand_t b;
        operand_t c;  // for MOV, c.ind selects the constant form
    } instr_fields_t;

    // one memory word, seen as plain data or as an instruction
    typedef union packed {
        data_t         raw;
        instr_fields_t instr;
    } mem_word_u;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_t;

    typedef enum logic [1:0] {WR_IN, WR_CONST, WR_OPB, WR_ALU} wr_src_t;

    typedef struct packed {
        logic    opa_ld;
        logic    opb_ld;
        logic    opc_ld;
        logic    alu_ld;
        logic    out_ld;
        logic    wr_ld;
        wr_src_t wr_src;
        alu_op_t alu_op;
        data_t   imm;     // second word of a MOV with constant
    } dp_ctrl_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } mem_req_t;

endpackage
